/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= sources.f
TB_TOP     ?= tb_jacobi_angle_prep
RTL_TOP    ?= jacobi_angle_prep_top
RTL_FILES  ?= jacobi_pkg.sv jacobi_matrix_store.sv jacobi_pair_scheduler.sv \
              jacobi_pair_operands.sv jacobi_operand_drain.sv jacobi_angle_prep_top.sv
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Simulation failed
PASS_MSG   ?= Simulation passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) +incdir+. --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(VERILATOR) $(SIM_FLAGS) -Mdir $(OBJ_DIR) -f $(FILELIST) --top-module $(TB_TOP)
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* jacobi_angle_prep_top.sv */
`include "jacobi_defines.svh"

module jacobi_angle_prep_top
  import jacobi_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  input  elem_t    in_dat_i,
  input  logic     in_vld_i,
  output logic     in_rdy_o,

  output operand_t out_dat_o,
  output logic     out_vld_o,
  input  logic     out_rdy_i
);

  logic                       load_en;
  logic                       load_done;
  logic                       start;
  logic                       take;
  pair_vec_t                  pair_vec;
  round_t                     round;
  matrix_t                    matrix;
  logic [`JACOBI_N_PAIRS-1:0] res_vld;
  operand_t                   res [`JACOBI_N_PAIRS];

  jacobi_matrix_store store0 (
    .clk         (clk),
    .rst         (rst),
    .in_dat_i    (in_dat_i),
    .in_vld_i    (in_vld_i),
    .in_rdy_o    (in_rdy_o),
    .load_en_i   (load_en),
    .load_done_o (load_done),
    .matrix_o    (matrix)
  );

  jacobi_pair_scheduler sched0 (
    .clk         (clk),
    .rst         (rst),
    .load_en_o   (load_en),
    .load_done_i (load_done),
    .take_i      (take),
    .start_o     (start),
    .pair_vec_o  (pair_vec),
    .round_o     (round)
  );

  // One unit per disjoint pair of the round
  for (genvar k = 0; k < `JACOBI_N_PAIRS; k++) begin : g_pair
    jacobi_pair_operands unit (
      .clk       (clk),
      .rst       (rst),
      .start_i   (start),
      .pair_i    (pair_vec[k]),
      .round_i   (round),
      .matrix_i  (matrix),
      .take_i    (take),
      .res_vld_o (res_vld[k]),
      .res_o     (res[k])
    );
  end

  jacobi_operand_drain drain0 (
    .clk       (clk),
    .rst       (rst),
    .res_vld_i (res_vld),
    .res_i     (res),
    .take_o    (take),
    .out_dat_o (out_dat_o),
    .out_vld_o (out_vld_o),
    .out_rdy_i (out_rdy_i)
  );

endmodule

/* jacobi_defines.svh */
`ifndef JACOBI_DEFINES_SVH
`define JACOBI_DEFINES_SVH

// Matrix geometry
`define JACOBI_N        8
`define JACOBI_LOG2_N   3
`define JACOBI_N_WORDS  (`JACOBI_N * `JACOBI_N)

// Element width and operand width
// One extra bit keeps Wjj - Wii and 2*Wij in range
`define JACOBI_ELEM_W   16
`define JACOBI_OPER_W   (`JACOBI_ELEM_W + 1)

// Round-robin ordering
`define JACOBI_N_PAIRS  (`JACOBI_N / 2)
`define JACOBI_N_ROUNDS (`JACOBI_N - 1)

`endif

/* jacobi_matrix_store.sv */
`include "jacobi_defines.svh"

module jacobi_matrix_store
  import jacobi_pkg::*;
(
  input  logic    clk,
  input  logic    rst,

  // Host stream
  input  elem_t   in_dat_i,
  input  logic    in_vld_i,
  output logic    in_rdy_o,

  // Scheduler side
  input  logic    load_en_i,
  output logic    load_done_o,

  output matrix_t matrix_o
);

  localparam int CNT_W = $clog2(`JACOBI_N_WORDS);

  logic [CNT_W-1:0] word_cnt_q;
  matrix_t          mat_q;
  logic             accept;
  logic             last_word;

  assign in_rdy_o    = load_en_i;
  assign accept      = in_vld_i && load_en_i;
  assign last_word   = (word_cnt_q == CNT_W'(`JACOBI_N_WORDS - 1));
  assign load_done_o = accept && last_word;

  // Word counter doubles as the write address
  always_ff @(posedge clk) begin
    if (rst) begin
      word_cnt_q <= '0;
    end else if (accept) begin
      if (last_word) begin
        word_cnt_q <= '0;
      end else begin
        word_cnt_q <= word_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      mat_q[word_cnt_q] <= in_dat_i;
    end
  end

  assign matrix_o = mat_q;

endmodule

/* jacobi_operand_drain.sv */
`include "jacobi_defines.svh"

module jacobi_operand_drain
  import jacobi_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`JACOBI_N_PAIRS-1:0] res_vld_i,
  input  operand_t                   res_i [`JACOBI_N_PAIRS],
  output logic                       take_o,
  output operand_t                   out_dat_o,
  output logic                       out_vld_o,
  input  logic                       out_rdy_i
);

  localparam int P     = `JACOBI_N_PAIRS;
  localparam int CNT_W = $clog2(P + 1);

  operand_t         buf_q [P];
  logic [CNT_W-1:0] cnt_q;
  logic             pop;
  logic             room;

  assign out_vld_o = (cnt_q != '0);
  assign pop       = out_vld_o && out_rdy_i;

  // Empty now, or the last word leaves this cycle
  assign room   = (cnt_q == '0) || ((cnt_q == CNT_W'(1)) && out_rdy_i);
  assign take_o = (&res_vld_i) && room;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (take_o) begin
      cnt_q <= CNT_W'(P);
    end else if (pop) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Entry 0 is the head so words leave in pair order
  always_ff @(posedge clk) begin
    if (take_o) begin
      for (int k = 0; k < P; k++) begin
        buf_q[k] <= res_i[k];
      end
    end else if (pop) begin
      for (int k = 0; k < P - 1; k++) begin
        buf_q[k] <= buf_q[k+1];
      end
    end
  end

  assign out_dat_o = buf_q[0];

endmodule

/* jacobi_pair_operands.sv */
`include "jacobi_defines.svh"

module jacobi_pair_operands
  import jacobi_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     start_i,
  input  pair_t    pair_i,
  input  round_t   round_i,
  input  matrix_t  matrix_i,
  input  logic     take_i,
  output logic     res_vld_o,
  output operand_t res_o
);

  logic signed [`JACOBI_OPER_W-1:0] w_ii;
  logic signed [`JACOBI_OPER_W-1:0] w_jj;
  logic signed [`JACOBI_OPER_W-1:0] w_ij;
  operand_t                         res_q;
  logic                             vld_q;

  // Signed element into the wider operand sign-extends
  assign w_ii = matrix_i[{pair_i.i, pair_i.i}];
  assign w_jj = matrix_i[{pair_i.j, pair_i.j}];
  assign w_ij = matrix_i[{pair_i.i, pair_i.j}];

  always_ff @(posedge clk) begin
    if (start_i) begin
      res_q.round <= round_i;
      res_q.pair  <= pair_i;
      res_q.x     <= w_jj - w_ii;
      res_q.y     <= w_ij <<< 1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= 1'b0;
    end else if (start_i) begin
      vld_q <= 1'b1;
    end else if (take_i) begin
      vld_q <= 1'b0;
    end
  end

  assign res_vld_o = vld_q;
  assign res_o     = res_q;

endmodule

/* jacobi_pair_scheduler.sv */
`include "jacobi_defines.svh"

module jacobi_pair_scheduler
  import jacobi_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  output logic      load_en_o,
  input  logic      load_done_i,

  input  logic      take_i,
  output logic      start_o,
  output pair_vec_t pair_vec_o,
  output round_t    round_o
);

  localparam int P = `JACOBI_N_PAIRS;

  sched_state_t state_q;
  pair_vec_t    pairs_q;
  pair_vec_t    pairs_next;
  round_t       round_q;
  logic         last_round;

  // Round 0 pairs (k, N-1-k)
  function automatic pair_vec_t init_pairs();
    pair_vec_t p;
    for (int k = 0; k < P; k++) begin
      p[k].i = idx_t'(k);
      p[k].j = idx_t'(`JACOBI_N - 1 - k);
    end
    return p;
  endfunction

  // Tops move left, bottoms move right, top of pair 0 is fixed
  always_comb begin
    pairs_next[0].i = pairs_q[0].i;
    for (int k = 1; k < P - 1; k++) begin
      pairs_next[k].i = pairs_q[k+1].i;
    end
    pairs_next[P-1].i = pairs_q[P-1].j;
    for (int k = P - 1; k > 0; k--) begin
      pairs_next[k].j = pairs_q[k-1].j;
    end
    pairs_next[0].j = pairs_q[1].i;
  end

  assign last_round = (round_q == round_t'(`JACOBI_N_ROUNDS - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= LOAD;
      pairs_q <= init_pairs();
      round_q <= '0;
    end else begin
      case (state_q)
        LOAD: begin
          pairs_q <= init_pairs();
          round_q <= '0;
          if (load_done_i) begin
            state_q <= START;
          end
        end
        START: begin
          state_q <= WAIT_TAKE;
        end
        WAIT_TAKE: begin
          if (take_i) begin
            if (last_round) begin
              state_q <= LOAD;
            end else begin
              state_q <= START;
              pairs_q <= pairs_next;
              round_q <= round_q + 1'b1;
            end
          end
        end
        default: state_q <= LOAD;
      endcase
    end
  end

  assign load_en_o  = (state_q == LOAD);
  assign start_o    = (state_q == START);
  assign pair_vec_o = pairs_q;
  assign round_o    = round_q;

endmodule

/* jacobi_pkg.sv */
`include "jacobi_defines.svh"

package jacobi_pkg;

  typedef logic signed [`JACOBI_ELEM_W-1:0] elem_t;

  typedef logic [`JACOBI_LOG2_N-1:0] idx_t;

  typedef logic [$clog2(`JACOBI_N_ROUNDS)-1:0] round_t;

  typedef struct packed {
    idx_t i;
    idx_t j;
  } pair_t;

  typedef pair_t [`JACOBI_N_PAIRS-1:0] pair_vec_t;

  // Element k sits at row k/N and column k%N
  typedef elem_t [`JACOBI_N_WORDS-1:0] matrix_t;

  typedef struct packed {
    round_t                           round;
    pair_t                            pair;
    logic signed [`JACOBI_OPER_W-1:0] x;
    logic signed [`JACOBI_OPER_W-1:0] y;
  } operand_t;

  typedef enum logic [1:0] {LOAD, START, WAIT_TAKE} sched_state_t;

endpackage

/* sources.f */
+incdir+.
jacobi_pkg.sv
jacobi_matrix_store.sv
jacobi_pair_scheduler.sv
jacobi_pair_operands.sv
jacobi_operand_drain.sv
jacobi_angle_prep_top.sv
tb_jacobi_checker.sv
tb_jacobi_angle_prep.sv

/* tb_jacobi_angle_prep.sv */
`include "jacobi_defines.svh"

module tb_jacobi_angle_prep
  import jacobi_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          N           = `JACOBI_N;
  localparam int          N_WORDS     = `JACOBI_N_WORDS;
  localparam logic [31:0] SEED        = 32'd64802;
  localparam int          TIMEOUT_CYC = 2000;

  logic        clk;
  logic        rst;
  elem_t       in_dat_i;
  logic        in_vld_i;
  logic        in_rdy_o;
  operand_t    out_dat_o;
  logic        out_vld_o;
  logic        out_rdy_i;
  int          test_id;
  logic        test_end;
  logic        stall_en;
  logic        hung;
  int          err_cnt;
  int          chk_cnt;
  int          pending;
  logic [31:0] rng_state;
  logic [31:0] rdy_state;
  elem_t       mat [N_WORDS];

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  jacobi_angle_prep_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .in_dat_i  (in_dat_i),
    .in_vld_i  (in_vld_i),
    .in_rdy_o  (in_rdy_o),
    .out_dat_o (out_dat_o),
    .out_vld_o (out_vld_o),
    .out_rdy_i (out_rdy_i)
  );

  tb_jacobi_checker chk0 (
    .clk        (clk),
    .rst        (rst),
    .in_dat_i   (in_dat_i),
    .in_vld_i   (in_vld_i),
    .in_rdy_i   (in_rdy_o),
    .out_dat_i  (out_dat_o),
    .out_vld_i  (out_vld_o),
    .out_rdy_i  (out_rdy_i),
    .test_id_i  (test_id),
    .test_end_i (test_end),
    .err_cnt_o  (err_cnt),
    .chk_cnt_o  (chk_cnt),
    .pending_o  (pending)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Output ready drops about a quarter of the time while stalls are on
  initial begin
    rdy_state = SEED ^ 32'h2545_f491;
    out_rdy_i = 1'b1;
    forever begin
      @(negedge clk);
      if (stall_en) begin
        rdy_state = xorshift32(rdy_state);
        out_rdy_i = (rdy_state[1:0] != 2'b00);
      end else begin
        out_rdy_i = 1'b1;
      end
    end
  end

  // Upper triangle random, lower triangle mirrored
  task automatic fill_matrix(input logic full_scale);
    logic [31:0] r;
    for (int row = 0; row < N; row++) begin
      for (int col = 0; col < N; col++) begin
        r = next_rand();
        if (col < row) begin
          mat[row*N + col] = mat[col*N + row];
        end else if (full_scale) begin
          mat[row*N + col] = r[0] ? elem_t'(16'h7fff) : elem_t'(16'h8000);
        end else begin
          mat[row*N + col] = elem_t'(r[15:0]);
        end
      end
    end
  endtask

  task automatic send_word(input elem_t w);
    int waited;
    waited = 0;
    in_dat_i = w;
    in_vld_i = 1'b1;
    while (!in_rdy_o && !hung) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT_CYC) begin
        $display("Timeout: DUT did not accept an input word in %0d cycles", TIMEOUT_CYC);
        hung = 1'b1;
      end
    end
    @(negedge clk);
  endtask

  task automatic send_matrix(input logic gaps);
    logic [31:0] r;
    for (int k = 0; k < N_WORDS && !hung; k++) begin
      if (gaps) begin
        r = next_rand();
        in_vld_i = 1'b0;
        in_dat_i = elem_t'(r[31:16]);
        repeat (r[1:0]) @(negedge clk);
      end
      send_word(mat[k]);
    end
    in_vld_i = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while ((pending != 0 || out_vld_o) && !hung) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT_CYC) begin
        $display("Timeout: DUT still owes %0d results after %0d cycles", pending, TIMEOUT_CYC);
        hung = 1'b1;
      end
    end
  endtask

  task automatic reset_dut();
    rst = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic set_stall(input logic en);
    @(posedge clk);
    stall_en = en;
    @(negedge clk);
  endtask

  task automatic run_test(input int id);
    test_id = id;
    case (id)
      2: begin
        set_stall(1'b1);
        fill_matrix(1'b0);
        send_matrix(1'b0);
        wait_drained();
        set_stall(1'b0);
      end
      3: begin
        fill_matrix(1'b0);
        send_matrix(1'b1);
      end
      4: begin
        fill_matrix(1'b0);
        send_matrix(1'b0);
        fill_matrix(1'b0);
        send_matrix(1'b0);
      end
      5: begin
        fill_matrix(1'b1);
        send_matrix(1'b0);
      end
      6: begin
        fill_matrix(1'b0);
        send_matrix(1'b0);
        repeat (12) @(negedge clk);
        reset_dut();
        fill_matrix(1'b0);
        send_matrix(1'b0);
      end
      default: begin
        fill_matrix(1'b0);
        send_matrix(1'b0);
      end
    endcase
    wait_drained();
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  initial begin
    rst       = 1'b1;
    in_dat_i  = '0;
    in_vld_i  = 1'b0;
    stall_en  = 1'b0;
    hung      = 1'b0;
    test_id   = 0;
    test_end  = 1'b0;
    rng_state = SEED;
    reset_dut();
    for (int t = 1; t <= 6 && !hung; t++) begin
      run_test(t);
    end
    $display("Totals: %0d outputs checked, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0 && !hung) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* tb_jacobi_checker.sv */
`include "jacobi_defines.svh"

module tb_jacobi_checker
  import jacobi_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  elem_t    in_dat_i,
  input  logic     in_vld_i,
  input  logic     in_rdy_i,
  input  operand_t out_dat_i,
  input  logic     out_vld_i,
  input  logic     out_rdy_i,
  input  int       test_id_i,
  input  logic     test_end_i,
  output int       err_cnt_o,
  output int       chk_cnt_o,
  output int       pending_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N   = `JACOBI_N;
  localparam int P   = `JACOBI_N_PAIRS;
  localparam int OPW = `JACOBI_OPER_W;

  elem_t    mat [`JACOBI_N_WORDS];
  operand_t exp_q [$];
  operand_t exp_w;
  operand_t held;
  logic     stalled = 1'b0;
  logic     in_reset = 1'b0;
  int       word_cnt = 0;
  int       err_cnt = 0;
  int       chk_cnt = 0;
  int       test_err = 0;
  int       test_chk = 0;
  int       pending = 0;

  function automatic string test_name(input int id);
    case (id)
      1: return "random_full_rate";
      2: return "out_backpressure";
      3: return "in_gaps";
      4: return "back_to_back";
      5: return "full_scale";
      6: return "reset_mid_round";
      default: return "idle";
    endcase
  endfunction

  function automatic string word_text(input operand_t w);
    return $sformatf("r%0d (%0d,%0d) x=%0d y=%0d", w.round, w.pair.i, w.pair.j, w.x, w.y);
  endfunction

  // One word per pair with x = Wjj - Wii and y = 2*Wij
  function automatic void build_expected(input elem_t m [`JACOBI_N_WORDS]);
    int       top [P];
    int       bot [P];
    int       nt [P];
    int       nb [P];
    int       x;
    int       y;
    operand_t w;
    for (int k = 0; k < P; k++) begin
      top[k] = k;
      bot[k] = N - 1 - k;
    end
    for (int r = 0; r < `JACOBI_N_ROUNDS; r++) begin
      for (int k = 0; k < P; k++) begin
        x = int'(m[bot[k]*N + bot[k]]) - int'(m[top[k]*N + top[k]]);
        y = 2 * int'(m[top[k]*N + bot[k]]);
        w.round  = round_t'(r);
        w.pair.i = idx_t'(top[k]);
        w.pair.j = idx_t'(bot[k]);
        w.x      = OPW'(x);
        w.y      = OPW'(y);
        exp_q.push_back(w);
      end
      // Top of position 0 stays and the rest turn as one ring
      nt[0] = top[0];
      nt[1] = top[2];
      nt[2] = top[3];
      nt[3] = bot[3];
      nb[3] = bot[2];
      nb[2] = bot[1];
      nb[1] = bot[0];
      nb[0] = top[1];
      top = nt;
      bot = nb;
    end
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      word_cnt = 0;
      exp_q.delete();
      stalled = 1'b0;
      in_reset = 1'b1;
    end else begin
      if (in_reset && (out_vld_i || !in_rdy_i)) begin
        $display("After reset the output is valid or the input is not ready in test %s",
                 test_name(test_id_i));
        err_cnt++;
        test_err++;
      end
      in_reset = 1'b0;
      if (in_vld_i && in_rdy_i) begin
        mat[word_cnt] = in_dat_i;
        word_cnt++;
        if (word_cnt == `JACOBI_N_WORDS) begin
          build_expected(mat);
          word_cnt = 0;
        end
      end
      if (stalled && (!out_vld_i || (out_dat_i !== held))) begin
        $display("Output word changed or lost its valid during a stall in test %s",
                 test_name(test_id_i));
        err_cnt++;
        test_err++;
      end
      if (out_vld_i && out_rdy_i) begin
        if (exp_q.size() == 0) begin
          $display("DUT sent an output with no matrix behind it in test %s",
                   test_name(test_id_i));
          err_cnt++;
          test_err++;
        end else begin
          exp_w = exp_q.pop_front();
          chk_cnt++;
          test_chk++;
          if (out_dat_i !== exp_w) begin
            $display("[FAIL] %s: expected %s, actual %s", test_name(test_id_i),
                     word_text(exp_w), word_text(out_dat_i));
            err_cnt++;
            test_err++;
          end
        end
      end
      stalled = out_vld_i && !out_rdy_i;
      held    = out_dat_i;
    end
    if (test_end_i) begin
      $display("Test %s: %0d outputs checked, %0d errors",
               test_name(test_id_i), test_chk, test_err);
      test_chk = 0;
      test_err = 0;
    end
    pending = exp_q.size();
  end

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;
  assign pending_o = pending;

endmodule
